//--- compile.f
+incdir+include
logic/gpioPkg.sv
logic/gpioCmdDecode.sv
logic/gpioDutyExec.sv
logic/gpioLedResult.sv
logic/gpioUnit.sv
verif/tbClock.sv
verif/gpioUnit_assertions.sv
verif/gpioTb.sv

//--- verif/gpioTb.sv
// LED block testbench
// Directed tests for static, blink and PWM modes and the credit channel

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioTb;

	localparam int LedN     = `GPIO_LED_NUM;
	localparam int MaxPulse = (1 << `GPIO_PWM_WIDTH) - 1;
	// Tests need about 1900 cycles, PWM ramps dominate
	localparam int MaxCycles = 4000;

	logic                iSysClk;
	logic                rstN;
	logic                cmdValid;
	gpioPkg::gpioCmdWord cmdWord;
	logic                cmdCredit;
	logic [1:0]          led;
	logic                ledR;
	logic                ledG;
	logic                ledB;

	logic [31:0] lfsrState;
	int          creditsSpent;
	int          creditsBack;
	int          cycleCount;
	int          errCount;

	tbClock clkGen (.iSysClk(iSysClk), .rstN(rstN));

	gpioUnit dut_i
	(
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.cmdValid  (cmdValid),
		.cmdWord   (cmdWord),
		.cmdCredit (cmdCredit),
		.led       (led),
		.ledR      (ledR),
		.ledG      (ledG),
		.ledB      (ledB)
	);

	// Host side count of returned credits
	always @(posedge iSysClk)
	begin
		if (!rstN)
			creditsBack <= 0;
		else if (cmdCredit)
			creditsBack <= creditsBack + 1;
	end

	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= MaxCycles)
		begin
			$display("Timeout: tests still running after %0d clock cycles", MaxCycles);
			$display("Errors found");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// Failures flagged by the bound decode checks
	always @(negedge iSysClk)
	begin
		if (dut_i.uDecode.uChecks.failCount != 0)
		begin
			$display("A credit or FIFO assertion failed in the command decode stage");
			$display("Errors found");
			$fatal(1, "Run stopped by an assertion failure");
		end
	end

	//------------------------------------------------------------
	// Stimulus helpers
	//------------------------------------------------------------
	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			val       = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic gpioPkg::gpioCmdWord cfgWord(input gpioPkg::gpioMode mode,
		input logic [LedN-1:0] en);
		gpioPkg::gpioCmdWord w;
		w            = '0;
		w.cfg.mode   = mode;
		w.cfg.enable = en;
		return w;
	endfunction

	function automatic gpioPkg::gpioCmdWord timerWord(input logic [2:0] idx,
		input logic [`GPIO_IV_WIDTH-1:0] iv);
		gpioPkg::gpioCmdWord w;
		w                = '0;
		w.timer.opTimer  = 1'b1;
		w.timer.ledIdx   = idx;
		w.timer.interval = iv;
		return w;
	endfunction

	// LED state seen through the pin polarity
	function automatic logic [LedN-1:0] pinState();
		return {~ledB, ~ledG, ~ledR, led};
	endfunction

	// Called on a falling edge, returns on the next one
	task automatic sendCmd(input gpioPkg::gpioCmdWord w);
		while (creditsSpent - creditsBack >= `GPIO_CMD_DEPTH)
			@(negedge iSysClk);
		cmdValid = 1'b1;
		cmdWord  = w;
		creditsSpent++;
		@(negedge iSysClk);
		cmdValid = 1'b0;
	endtask

	// Decode edge, then the pin register edge
	task automatic settle();
		repeat (2) @(posedge iSysClk);
		@(negedge iSysClk);
	endtask

	task automatic waitChange(input int idx, output int cycles);
		logic [LedN-1:0] pins;
		logic            start;
		pins   = pinState();
		start  = pins[idx];
		cycles = 0;
		do
		begin
			@(negedge iSysClk);
			cycles++;
			pins = pinState();
		end
		while (pins[idx] == start);
	endtask

	//------------------------------------------------------------
	// Checks
	//------------------------------------------------------------
	task automatic flagError(input string msg);
		errCount++;
		$display("** Error at %0t: %s", $time, msg);
		$display("Errors found");
		$fatal(1, "Stopped at the first mismatch");
	endtask

	task automatic compareLeds(input logic [LedN-1:0] expEn, input logic [LedN-1:0] care,
		input string what);
		logic [LedN-1:0] expPins;
		logic [LedN-1:0] gotPins;
		// Plain LEDs active high, RGB active low
		expPins = {~expEn[4:2], expEn[1:0]};
		gotPins = {ledB, ledG, ledR, led};
		if (((expPins ^ gotPins) & care) !== '0)
			flagError($sformatf("%s: pins %b, expected %b", what, gotPins, expPins));
	endtask

	task automatic compareCount(input int got, input int expVal, input string what);
		if (got != expVal)
			flagError($sformatf("%s: measured %0d, expected %0d", what, got, expVal));
	endtask

	//------------------------------------------------------------
	// Directed tests
	//------------------------------------------------------------
	task automatic testStatic();
		logic [LedN-1:0] en;
		compareLeds('0, '1, "dark after reset");
		for (int i = 0; i < 8; i++)
		begin
			en = LedN'(randBits(LedN));
			sendCmd(cfgWord(gpioPkg::modeStatic, en));
			settle();
			compareLeds(en, '1, "static enable");
		end
	endtask

	task automatic testBlink();
		logic [`GPIO_IV_WIDTH-1:0] iv [LedN];
		logic                      dup;
		int                        period;
		for (int i = 0; i < LedN; i++)
		begin
			do
			begin
				iv[i] = `GPIO_IV_WIDTH'(3 + randBits(4));
				dup   = 1'b0;
				for (int j = 0; j < i; j++)
					dup = dup | (iv[j] == iv[i]);
			end
			while (dup);
			sendCmd(timerWord(3'(i), iv[i]));
		end
		sendCmd(cfgWord(gpioPkg::modeBlink, '1));
		settle();
		for (int i = 0; i < LedN; i++)
		begin
			// First toggle marks a tick, the next one closes a full period
			waitChange(i, period);
			waitChange(i, period);
			compareCount(period, int'(iv[i]) + 1, $sformatf("blink period of LED %0d", i));
		end
	endtask

	task automatic testBlinkDisabled();
		logic [LedN-1:0] en;
		en = LedN'(randBits(LedN));
		if (en == '1)
			en[0] = 1'b0;
		sendCmd(cfgWord(gpioPkg::modeBlink, en));
		settle();
		repeat (100)
		begin
			compareLeds('0, ~en, "disabled LED in blink mode");
			@(negedge iSysClk);
		end
	endtask

	task automatic testPwm();
		logic [LedN-1:0] en;
		logic [LedN-1:0] pins;
		int              len;
		int              expLen;
		en = LedN'(randBits(LedN));
		if (en == '0)
			en[LedN-1] = 1'b1;
		// At least one LED stays off for the dark check
		if (en == '1)
			en[0] = 1'b0;
		sendCmd(cfgWord(gpioPkg::modePwm, en));
		settle();
		for (int i = 0; i < LedN; i++)
		begin
			if (en[i])
			begin
				pins = pinState();
				if (pins[i])
					waitChange(i, len);
				// First whole pulse fixes where the ramp stands
				waitChange(i, len);
				waitChange(i, expLen);
				for (int k = 0; k < MaxPulse + 1; k++)
				begin
					expLen = (expLen >= MaxPulse) ? 1 : expLen + 1;
					waitChange(i, len);
					waitChange(i, len);
					compareCount(len, expLen, $sformatf("PWM pulse of LED %0d", i));
				end
			end
		end
		repeat (32)
		begin
			compareLeds('0, ~en, "disabled LED in PWM mode");
			@(negedge iSysClk);
		end
	endtask

	task automatic testCredits();
		logic [LedN-1:0] en;
		int              startBack;
		// Full credit pool before the burst
		while (creditsSpent != creditsBack)
			@(negedge iSysClk);
		startBack = creditsBack;
		for (int k = 0; k < `GPIO_CMD_DEPTH - 1; k++)
			sendCmd(cfgWord(gpioPkg::modeBlink, LedN'(randBits(LedN))));
		en = LedN'(randBits(LedN));
		sendCmd(cfgWord(gpioPkg::modeStatic, en));
		settle();
		compareLeds(en, '1, "last command of a back to back burst");
		while (creditsBack - startBack < `GPIO_CMD_DEPTH)
			@(negedge iSysClk);
		repeat (8) @(negedge iSysClk);
		compareCount(creditsBack - startBack, `GPIO_CMD_DEPTH, "credit pulses returned");
	endtask

	initial
	begin
		cmdValid     = 1'b0;
		cmdWord      = '0;
		lfsrState    = 32'hf835c2a8;
		creditsSpent = 0;
		errCount     = 0;
		wait (rstN === 1'b1);
		@(negedge iSysClk);
		testStatic();
		testBlink();
		testBlinkDisabled();
		testPwm();
		testCredits();
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verif/gpioUnit_assertions.sv
// Command channel checks
// Credit accounting, FIFO occupancy and reset values of the decode stage

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioUnit_assertions
(
	input logic                                 iSysClk,
	input logic                                 rstN,
	input logic                                 cmdValid,
	input logic                                 cmdCredit,
	input logic                                 fifoFull,
	input logic [$clog2(`GPIO_CMD_DEPTH+1)-1:0] fifoCount
);

	// Credits currently held on the decode side
	logic [7:0] outstanding;

	// Number of failed checks so far
	int failCount;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			outstanding <= '0;
		else
			outstanding <= outstanding + 8'(cmdValid) - 8'(cmdCredit);
	end

	noWriteWhenFull: assert property (@(posedge iSysClk) disable iff (!rstN)
		!(cmdValid && fifoFull))
		else
		begin
			failCount++;
			$error("Command FIFO written while full");
		end

	creditLimit: assert property (@(posedge iSysClk) disable iff (!rstN)
		outstanding <= 8'(`GPIO_CMD_DEPTH))
		else
		begin
			failCount++;
			$error("Outstanding credits exceed the FIFO depth");
		end

	// Quiet channel right out of reset
	resetValues: assert property (@(posedge iSysClk)
		!rstN |=> (!cmdCredit && fifoCount == '0))
		else
		begin
			failCount++;
			$error("Credit pulse or buffered word right after reset");
		end

endmodule

bind gpioCmdDecode gpioUnit_assertions uChecks
(
	.iSysClk   (iSysClk),
	.rstN      (rstN),
	.cmdValid  (cmdValid),
	.cmdCredit (cmdCredit),
	.fifoFull  (fifoFull),
	.fifoCount (fifoCount)
);

//--- verif/tbClock.sv
// Testbench clock and reset
// Free running clock with a synchronous active-low reset pulse

`timescale 1ns/1ps

module tbClock
#(
	parameter real PeriodNs    = 100.0,
	parameter int  ResetCycles = 2
)
(
	output logic iSysClk,
	output logic rstN
);

	initial
	begin
		iSysClk = 1'b0;
		forever
			#(PeriodNs / 2.0) iSysClk = ~iSysClk;
	end

	// Release on a falling edge, away from the sampling edge
	initial
	begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge iSysClk);
		@(negedge iSysClk);
		rstN = 1'b1;
	end

endmodule

//--- logic/gpioUnit.sv
// LED block top level
// Host commands enter over a credit channel, pass through decode,
// then the timing engine, and end at the pin registers

`timescale 1ns/1ps

module gpioUnit
(
	input  logic                iSysClk,
	input  logic                rstN,
	input  logic                cmdValid,
	input  gpioPkg::gpioCmdWord cmdWord,
	output logic                cmdCredit,
	output logic [1:0]          led,
	output logic                ledR,
	output logic                ledG,
	output logic                ledB
);

	gpioPkg::gpioCtrl  ctrl;
	gpioPkg::gpioDrive drive;

	gpioCmdDecode uDecode
	(
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.cmdValid  (cmdValid),
		.cmdWord   (cmdWord),
		.cmdCredit (cmdCredit),
		.ctrl      (ctrl)
	);

	gpioDutyExec uExec
	(
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.drive   (drive)
	);

	gpioLedResult uResult
	(
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.drive   (drive),
		.led     (led),
		.ledR    (ledR),
		.ledG    (ledG),
		.ledB    (ledB)
	);

endmodule

//--- logic/gpioLedResult.sv
// LED output stage
// Picks static, blink or PWM level per LED and registers the pins
// Plain LEDs are active high, RGB pins are active low

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioLedResult
(
	input  logic              iSysClk,
	input  logic              rstN,
	input  gpioPkg::gpioCtrl  ctrl,
	input  gpioPkg::gpioDrive drive,
	output logic [1:0]        led,
	output logic              ledR,
	output logic              ledG,
	output logic              ledB
);

	logic [`GPIO_LED_NUM-1:0] ledState;
	logic [`GPIO_LED_NUM-1:0] nextState;

	//------------------------------------------------------------
	// Mode select
	//------------------------------------------------------------
	always_comb
	begin
		case (ctrl.mode)
			// Toggle on tick, forced dark while disabled
			gpioPkg::modeBlink:
				nextState = ctrl.enable & (ledState ^ drive.tick);
			gpioPkg::modePwm:
				nextState = ctrl.enable & drive.pwm;
			default:
				nextState = ctrl.enable;
		endcase
	end

	//------------------------------------------------------------
	// State and pin registers
	//------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ledState <= '0;
			led      <= 2'b00;
			ledR     <= 1'b1;
			ledG     <= 1'b1;
			ledB     <= 1'b1;
		end
		else
		begin
			ledState <= nextState;
			led      <= nextState[1:0];
			ledR     <= ~nextState[2];
			ledG     <= ~nextState[3];
			ledB     <= ~nextState[4];
		end
	end

endmodule

//--- logic/gpioDutyExec.sv
// LED timing engine
// One lane per LED with a blink interval timer and a PWM ramp
// whose duty climbs by one every PWM period

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioDutyExec
(
	input  logic              iSysClk,
	input  logic              rstN,
	input  gpioPkg::gpioCtrl  ctrl,
	output gpioPkg::gpioDrive drive
);

	localparam logic [`GPIO_PWM_WIDTH-1:0] PhaseMax = '1;

	gpioPkg::gpioMode prevMode;
	logic [`GPIO_LED_NUM-1:0][`GPIO_IV_WIDTH-1:0] prevInterval;

	logic                     modeChg;
	logic [`GPIO_LED_NUM-1:0] ivRestart;
	logic [`GPIO_LED_NUM-1:0] tickVec;
	logic [`GPIO_LED_NUM-1:0] pwmVec;

	//------------------------------------------------------------
	// Change detection
	//------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			prevMode     <= gpioPkg::modeStatic;
			prevInterval <= '0;
		end
		else
		begin
			prevMode     <= ctrl.mode;
			prevInterval <= ctrl.interval;
		end
	end

	assign modeChg = (ctrl.mode != prevMode);

	//------------------------------------------------------------
	// Per-LED lanes
	//------------------------------------------------------------
	for (genvar i = 0; i < `GPIO_LED_NUM; i++)
	begin : genLane
		logic [`GPIO_IV_WIDTH-1:0]  ivCnt;
		logic [`GPIO_PWM_WIDTH-1:0] phase;
		logic [`GPIO_PWM_WIDTH-1:0] duty;
		logic                       ivHit;

		assign ivRestart[i] = modeChg | (ctrl.interval[i] != prevInterval[i]);
		assign ivHit        = (ivCnt == ctrl.interval[i]);

		// No tick in the cycle the timer is being restarted
		assign tickVec[i] = ivHit & ~ivRestart[i];
		assign pwmVec[i]  = (phase < duty);

		// Interval timer, period is interval+1 cycles
		always_ff @(posedge iSysClk)
		begin
			if (!rstN)
				ivCnt <= '0;
			else if (ivRestart[i] || ivHit)
				ivCnt <= '0;
			else
				ivCnt <= ivCnt + 1'b1;
		end

		// Phase runs freely, duty steps on each phase wrap
		always_ff @(posedge iSysClk)
		begin
			if (!rstN || modeChg)
			begin
				phase <= '0;
				duty  <= '0;
			end
			else
			begin
				phase <= phase + 1'b1;
				if (phase == PhaseMax)
					duty <= duty + 1'b1;
			end
		end
	end

	assign drive.tick = tickVec;
	assign drive.pwm  = pwmVec;

endmodule

//--- logic/gpioCmdDecode.sv
// LED command decode
// Buffers host commands in a small FIFO, decodes one word per cycle
// into the control registers and returns one credit per word taken

`timescale 1ns/1ps
`include "gpio_macros.svh"

module gpioCmdDecode
(
	input  logic                iSysClk,
	input  logic                rstN,
	input  logic                cmdValid,
	input  gpioPkg::gpioCmdWord cmdWord,
	output logic                cmdCredit,
	output gpioPkg::gpioCtrl    ctrl
);

	localparam int PtrW = $clog2(`GPIO_CMD_DEPTH);
	localparam int CntW = $clog2(`GPIO_CMD_DEPTH + 1);
	localparam logic [PtrW-1:0] LastPtr = PtrW'(`GPIO_CMD_DEPTH - 1);

	gpioPkg::gpioCmdWord fifoMem [`GPIO_CMD_DEPTH];
	gpioPkg::gpioCmdWord headWord;

	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] fifoCount;
	logic            fifoFull;
	logic            pushEn;
	logic            popEn;

	//------------------------------------------------------------
	// Command FIFO
	//------------------------------------------------------------
	assign fifoFull = (fifoCount == CntW'(`GPIO_CMD_DEPTH));
	assign pushEn   = cmdValid & ~fifoFull;

	// Drain whenever anything is buffered, nothing downstream stalls
	assign popEn    = (fifoCount != '0);
	assign headWord = fifoMem[rdPtr];

	always_ff @(posedge iSysClk)
	begin
		if (pushEn)
			fifoMem[wrPtr] <= cmdWord;
	end

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoCount <= '0;
		end
		else
		begin
			if (pushEn)
				wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
			if (popEn)
				rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;

			case ({pushEn, popEn})
				2'b10:   fifoCount <= fifoCount + 1'b1;
				2'b01:   fifoCount <= fifoCount - 1'b1;
				default: fifoCount <= fifoCount;
			endcase
		end
	end

	//------------------------------------------------------------
	// Head word decode into control registers
	//------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			ctrl.mode     <= gpioPkg::modeStatic;
			ctrl.enable   <= '0;
			ctrl.interval <= '0;
		end
		else if (popEn)
		begin
			if (!headWord.cfg.opTimer)
			begin
				ctrl.mode   <= headWord.cfg.mode;
				ctrl.enable <= headWord.cfg.enable;
			end
			// Out of range LED index is dropped
			else if (headWord.timer.ledIdx < `GPIO_LED_NUM)
			begin
				ctrl.interval[headWord.timer.ledIdx] <= headWord.timer.interval;
			end
		end
	end

	// One credit back per word consumed
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			cmdCredit <= 1'b0;
		else
			cmdCredit <= popEn;
	end

endmodule

//--- logic/gpioPkg.sv
// LED block types
// Command word views, control register set and per-LED drive bundle

`include "gpio_macros.svh"

package gpioPkg;

	// Code 3 falls back to static behaviour
	typedef enum logic [1:0]
	{
		modeStatic = 2'd0,
		modeBlink  = 2'd1,
		modePwm    = 2'd2
	} gpioMode;

	// Config view, opTimer low
	typedef struct packed
	{
		logic                          opTimer;
		gpioMode                       mode;
		logic [`GPIO_LED_NUM-1:0]      enable;
		logic [32-3-`GPIO_LED_NUM-1:0] rsvd;
	} gpioCfgCmd;

	// Timer view, opTimer high
	typedef struct packed
	{
		logic                           opTimer;
		logic [2:0]                     ledIdx;
		logic [32-4-`GPIO_IV_WIDTH-1:0] rsvd;
		logic [`GPIO_IV_WIDTH-1:0]      interval;
	} gpioTimerCmd;

	// Bit 31 selects the view
	typedef union packed
	{
		gpioCfgCmd   cfg;
		gpioTimerCmd timer;
	} gpioCmdWord;

	typedef struct packed
	{
		gpioMode                                      mode;
		logic [`GPIO_LED_NUM-1:0]                     enable;
		logic [`GPIO_LED_NUM-1:0][`GPIO_IV_WIDTH-1:0] interval;
	} gpioCtrl;

	typedef struct packed
	{
		logic [`GPIO_LED_NUM-1:0] tick;
		logic [`GPIO_LED_NUM-1:0] pwm;
	} gpioDrive;

endpackage

//--- include/gpio_macros.svh
// LED block sizes
// Shared by the package and by every stage that builds per-LED logic

`ifndef GPIO_MACROS_SVH
`define GPIO_MACROS_SVH

// Two plain LEDs followed by the R, G and B pins at index 2, 3, 4
`define GPIO_LED_NUM    5

// PWM phase and duty counters, one period is 2**width cycles
`define GPIO_PWM_WIDTH  4

// Blink interval value
`define GPIO_IV_WIDTH   16

// Command FIFO depth, equal to the host's starting credit count
`define GPIO_CMD_DEPTH  4

`endif
